// ==== core_isa_pkg.sv ====
package core_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // machine sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int xlen        = 32;
  localparam int imem_words  = 64;
  localparam int imem_addr_w = 6;   // log2 of imem_words.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word views
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  // the same fetched word, seen as register fields or as immediate bits.
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } instr_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  localparam logic [6:0] funct7_alt = 7'b0100000;  // marks SUB and SRA.

endpackage

// ==== core_alu_pkg.sv ====
package core_alu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU operations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_eq,   // the four compares drive the branch flag.
    alu_ne,
    alu_lt,
    alu_ge
  } alu_op_t;

  typedef enum logic {
    opb_rs2,
    opb_imm
  } opb_sel_t;

  // write-back source for the destination register.
  typedef enum logic [1:0] {
    wb_alu,
    wb_imm,
    wb_pc4
  } wb_sel_t;

endpackage

// ==== instr_mem.sv ====
`timescale 1ns/1ns

module instr_mem (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                we_i,
  input  logic [core_isa_pkg::imem_addr_w-1:0] waddr_i,
  input  logic [core_isa_pkg::xlen-1:0]        wdata_i,
  input  logic [core_isa_pkg::xlen-1:0]        pc_i,
  output logic [core_isa_pkg::xlen-1:0]        instr_o
);
  import core_isa_pkg::*;

  logic [xlen-1:0]        mem [imem_words];
  logic [imem_addr_w-1:0] raddr;

  assign raddr = pc_i[imem_addr_w+1:2];  // byte address to word index.

  // program load port.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < imem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  assign instr_o = mem[raddr];

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [4:0]                   ra1_i,
  input  logic [4:0]                   ra2_i,
  input  logic [4:0]                   wa_i,
  input  logic                         we_i,
  input  logic [core_isa_pkg::xlen-1:0] wd_i,
  output logic [core_isa_pkg::xlen-1:0] rd1_o,
  output logic [core_isa_pkg::xlen-1:0] rd2_o
);
  import core_isa_pkg::*;

  logic [xlen-1:0] regs [32];

  // x0 is never written, so it keeps its reset value of zero.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa_i != 5'd0)) begin
      regs[wa_i] <= wd_i;
    end
  end

  assign rd1_o = regs[ra1_i];
  assign rd2_o = regs[ra2_i];

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
  input  core_isa_pkg::instr_u          instr_i,
  output core_alu_pkg::alu_op_t         alu_op_o,
  output core_alu_pkg::opb_sel_t        opb_sel_o,
  output core_alu_pkg::wb_sel_t         wb_sel_o,
  output logic [core_isa_pkg::xlen-1:0] imm_o,
  output logic                          rd_we_o,
  output logic                          branch_o,
  output logic                          jal_o,
  output logic                          illegal_o
);
  import core_isa_pkg::*;
  import core_alu_pkg::*;

  logic [xlen-1:0] imm_i_ext;
  logic [xlen-1:0] imm_b_ext;
  logic [xlen-1:0] imm_u_ext;
  logic [xlen-1:0] imm_j_ext;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // immediates, all taken from the I view of the word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign imm_i_ext = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};

  // the B format scatters its bits over the imm12 and rd slots.
  assign imm_b_ext = {{19{instr_i.i.imm12[11]}}, instr_i.i.imm12[11], instr_i.i.rd[0],
                      instr_i.i.imm12[10:5], instr_i.i.rd[4:1], 1'b0};

  assign imm_u_ext = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'b0};

  assign imm_j_ext = {{11{instr_i.i.imm12[11]}}, instr_i.i.imm12[11], instr_i.i.rs1,
                      instr_i.i.funct3, instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control decode, from the R view
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    alu_op_o  = alu_add;
    opb_sel_o = opb_rs2;
    wb_sel_o  = wb_alu;
    imm_o     = '0;
    rd_we_o   = 1'b0;
    branch_o  = 1'b0;
    jal_o     = 1'b0;
    illegal_o = 1'b0;

    case (instr_i.r.opcode)
      op_reg: begin
        rd_we_o = 1'b1;
        if (instr_i.r.funct7 == 7'b0) begin
          case (instr_i.r.funct3)
            f3_add_sub: alu_op_o = alu_add;
            f3_sll:     alu_op_o = alu_sll;
            f3_slt:     alu_op_o = alu_slt;
            f3_sltu:    alu_op_o = alu_sltu;
            f3_xor:     alu_op_o = alu_xor;
            f3_srl_sra: alu_op_o = alu_srl;
            f3_or:      alu_op_o = alu_or;
            default:    alu_op_o = alu_and;   // f3_and is the only one left.
          endcase
        end else if (instr_i.r.funct7 == funct7_alt && instr_i.r.funct3 == f3_add_sub) begin
          alu_op_o = alu_sub;
        end else if (instr_i.r.funct7 == funct7_alt && instr_i.r.funct3 == f3_srl_sra) begin
          alu_op_o = alu_sra;
        end else begin
          illegal_o = 1'b1;
        end
      end

      op_imm: begin
        rd_we_o   = 1'b1;
        opb_sel_o = opb_imm;
        imm_o     = imm_i_ext;
        case (instr_i.r.funct3)
          f3_add_sub: alu_op_o = alu_add;
          f3_slt:     alu_op_o = alu_slt;
          f3_xor:     alu_op_o = alu_xor;
          f3_or:      alu_op_o = alu_or;
          f3_and:     alu_op_o = alu_and;
          default:    illegal_o = 1'b1;  // no shift or unsigned immediates here.
        endcase
      end

      op_lui: begin
        rd_we_o  = 1'b1;
        wb_sel_o = wb_imm;
        imm_o    = imm_u_ext;
      end

      op_branch: begin
        branch_o = 1'b1;
        imm_o    = imm_b_ext;
        case (instr_i.r.funct3)
          f3_beq:  alu_op_o = alu_eq;
          f3_bne:  alu_op_o = alu_ne;
          f3_blt:  alu_op_o = alu_lt;
          f3_bge:  alu_op_o = alu_ge;
          default: illegal_o = 1'b1;
        endcase
      end

      op_jal: begin
        rd_we_o  = 1'b1;
        jal_o    = 1'b1;
        wb_sel_o = wb_pc4;
        imm_o    = imm_j_ext;
      end

      default: illegal_o = 1'b1;
    endcase

    // an illegal word has no architectural effect besides the PC step.
    if (illegal_o) begin
      rd_we_o  = 1'b0;
      branch_o = 1'b0;
      jal_o    = 1'b0;
    end
  end

endmodule

// ==== alu_execute.sv ====
`timescale 1ns/1ns

module alu_execute (
  input  core_alu_pkg::alu_op_t         alu_op_i,
  input  core_alu_pkg::opb_sel_t        opb_sel_i,
  input  logic [core_isa_pkg::xlen-1:0] rs1_data_i,
  input  logic [core_isa_pkg::xlen-1:0] rs2_data_i,
  input  logic [core_isa_pkg::xlen-1:0] imm_i,
  output logic [core_isa_pkg::xlen-1:0] result_o,
  output logic                          flag_o
);
  import core_isa_pkg::*;
  import core_alu_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic            eq;

  assign op_a  = rs1_data_i;
  assign op_b  = (opb_sel_i == opb_imm) ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];   // upper bits of B are ignored for shifts.

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;
  assign eq   = op_a == op_b;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result and compare flag
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    flag_o = 1'b0;
    case (alu_op_i)
      alu_eq:  flag_o = eq;
      alu_ne:  flag_o = !eq;
      alu_lt:  flag_o = lt_s;
      alu_ge:  flag_o = !lt_s;
      default: flag_o = 1'b0;
    endcase
  end

  always_comb begin
    case (alu_op_i)
      alu_add:  result_o = op_a + op_b;
      alu_sub:  result_o = op_a - op_b;
      alu_and:  result_o = op_a & op_b;
      alu_or:   result_o = op_a | op_b;
      alu_xor:  result_o = op_a ^ op_b;
      alu_sll:  result_o = op_a << shamt;
      alu_srl:  result_o = op_a >> shamt;
      alu_sra:  result_o = $unsigned($signed(op_a) >>> shamt);
      alu_slt:  result_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_u};
      default:  result_o = {{(xlen-1){1'b0}}, flag_o};  // compares show the flag.
    endcase
  end

endmodule

// ==== wb_result.sv ====
`timescale 1ns/1ns

module wb_result (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          en_i,
  input  core_alu_pkg::wb_sel_t         wb_sel_i,
  input  logic                          rd_we_i,
  input  logic                          branch_i,
  input  logic                          jal_i,
  input  logic                          flag_i,
  input  logic [core_isa_pkg::xlen-1:0] imm_i,
  input  logic [core_isa_pkg::xlen-1:0] alu_result_i,
  output logic [core_isa_pkg::xlen-1:0] pc_o,
  output logic [core_isa_pkg::xlen-1:0] wd_o,
  output logic                          we_o
);
  import core_isa_pkg::*;
  import core_alu_pkg::*;

  logic [imem_addr_w+1:0] pc_q;     // byte address inside the memory range.
  logic [imem_addr_w+1:0] pc_step;
  logic [xlen-1:0]        pc_plus4;
  logic                   take;

  assign pc_o     = {{(xlen-imem_addr_w-2){1'b0}}, pc_q};
  assign pc_plus4 = pc_o + 32'd4;
  assign take     = (branch_i && flag_i) || jal_i;
  assign pc_step  = take ? imm_i[imem_addr_w+1:0] : (imem_addr_w+2)'(4);

  always_comb begin
    case (wb_sel_i)
      wb_imm:  wd_o = imm_i;
      wb_pc4:  wd_o = pc_plus4;  // link address for JAL.
      default: wd_o = alu_result_i;
    endcase
  end

  assign we_o = rd_we_i && en_i;

  // the narrow adder wraps the PC within the memory.
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      pc_q <= '0;
    end else if (en_i) begin
      pc_q <= pc_q + pc_step;
    end
  end

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ns

module core_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 en_i,
  input  logic                                 imem_we_i,
  input  logic [core_isa_pkg::imem_addr_w-1:0] imem_addr_i,
  input  logic [core_isa_pkg::xlen-1:0]        imem_wdata_i,
  output logic [core_isa_pkg::xlen-1:0]        pc_o,
  output logic                                 retire_we_o,
  output logic [4:0]                           retire_rd_o,
  output logic [core_isa_pkg::xlen-1:0]        retire_data_o,
  output logic                                 illegal_o
);
  import core_isa_pkg::*;
  import core_alu_pkg::*;

  instr_u          instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] wd;
  alu_op_t         alu_op;
  opb_sel_t        opb_sel;
  wb_sel_t         wb_sel;
  logic            rd_we;
  logic            branch;
  logic            jal;
  logic            flag;
  logic            rf_we;

  instr_mem u_imem (
    .clk_i(clk_i), .rst_i(rst_i), .we_i(imem_we_i), .waddr_i(imem_addr_i),
    .wdata_i(imem_wdata_i), .pc_i(pc), .instr_o(instr)
  );

  instr_decode u_decode (
    .instr_i(instr), .alu_op_o(alu_op), .opb_sel_o(opb_sel), .wb_sel_o(wb_sel),
    .imm_o(imm), .rd_we_o(rd_we), .branch_o(branch), .jal_o(jal), .illegal_o(illegal_o)
  );

  reg_file u_rf (
    .clk_i(clk_i), .rst_i(rst_i), .ra1_i(instr.r.rs1), .ra2_i(instr.r.rs2),
    .wa_i(instr.r.rd), .we_i(rf_we), .wd_i(wd), .rd1_o(rs1_data), .rd2_o(rs2_data)
  );

  alu_execute u_alu (
    .alu_op_i(alu_op), .opb_sel_i(opb_sel), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .imm_i(imm), .result_o(alu_result), .flag_o(flag)
  );

  wb_result u_wb (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(en_i), .wb_sel_i(wb_sel), .rd_we_i(rd_we),
    .branch_i(branch), .jal_i(jal), .flag_i(flag), .imm_i(imm), .alu_result_i(alu_result),
    .pc_o(pc), .wd_o(wd), .we_o(rf_we)
  );

  // retire view of the instruction at pc in this cycle.
  assign pc_o          = pc;
  assign retire_we_o   = rf_we;
  assign retire_rd_o   = instr.r.rd;
  assign retire_data_o = wd;

endmodule

// ==== core_tb.sv ====
`timescale 1ns/1ns

module core_tb;

  localparam int half_period   = 20;
  localparam int reset_cycles  = 10;
  localparam int prog_len      = 30;
  localparam int pause_row     = 9;   // en_i drops after this row retires.
  localparam int timeout_limit = reset_cycles + prog_len * 2 + 20;

  logic        clk_i;
  logic        rst_i;
  logic        en_i;
  logic        imem_we_i;
  logic [5:0]  imem_addr_i;
  logic [31:0] imem_wdata_i;
  logic [31:0] pc_o;
  logic        retire_we_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_data_o;
  logic        illegal_o;

  // program table, one row per word address.
  logic [31:0] prog_word [64];
  logic        exp_we    [64];
  logic [4:0]  exp_rd    [64];
  logic [31:0] exp_data  [64];
  logic        exp_ill   [64];
  logic [31:0] exp_next  [64];
  logic [31:0] ref_x     [32];  // register values as the program leaves them.

  int     n_rows;
  int     error_count;
  int     cycle_count;
  integer seed;

  core_top uut (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(en_i), .imem_we_i(imem_we_i),
    .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i), .pc_o(pc_o),
    .retire_we_o(retire_we_o), .retire_rd_o(retire_rd_o),
    .retire_data_o(retire_data_o), .illegal_o(illegal_o)
  );

  always #half_period clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the program did not finish within %0d cycles", timeout_limit);
      error_count = error_count + 1;
      $display("errors: %0d", error_count);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      error_count = error_count + 1;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32I encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] sign_ext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] branch_instr(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_instr(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] this_pc();
    return 32'(n_rows * 4);
  endfunction

  function automatic logic [31:0] next_seq_pc();
    return 32'((n_rows + 1) * 4);
  endfunction

  task automatic add_row(input logic [31:0] word, input logic we, input logic [4:0] rd,
                         input logic [31:0] data, input logic ill, input logic [31:0] next_pc);
    prog_word[n_rows] = word;
    exp_we[n_rows]    = we;
    exp_rd[n_rows]    = rd;
    exp_data[n_rows]  = data;
    exp_ill[n_rows]   = ill;
    exp_next[n_rows]  = next_pc;
    if (we && rd != 5'd0) ref_x[rd] = data;  // x0 stays zero in the model.
    n_rows = n_rows + 1;
  endtask

  // a row that a taken branch or jump steps over.
  task automatic skip_row(input logic [31:0] word);
    prog_word[n_rows] = word;
    exp_we[n_rows]    = 1'b0;
    exp_next[n_rows]  = next_seq_pc();
    n_rows = n_rows + 1;
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic        taken;
    rnd   = $random(seed);
    imm_a = rnd[11:0];
    rnd   = $random(seed);
    imm_b = rnd[11:0];
    add_row(i_type(imm_a, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, sign_ext12(imm_a), 1'b0,
            next_seq_pc());
    add_row(i_type(12'hffb, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hfffffffb, 1'b0, next_seq_pc());
    add_row(lui_instr(20'h12345, 5'd3), 1'b1, 5'd3, 32'h12345000, 1'b0, next_seq_pc());
    add_row(i_type(imm_b, 5'd1, 3'b100, 5'd4), 1'b1, 5'd4, ref_x[1] ^ sign_ext12(imm_b),
            1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, ref_x[1] + ref_x[3], 1'b0,
            next_seq_pc());
    add_row(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd6), 1'b1, 5'd6, ref_x[3] - ref_x[2], 1'b0,
            next_seq_pc());
    add_row(r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd7), 1'b1, 5'd7, ref_x[3] & ref_x[4], 1'b0,
            next_seq_pc());
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 1'b1, 5'd8, ref_x[1] | ref_x[2], 1'b0,
            next_seq_pc());
    add_row(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd9), 1'b1, 5'd9, ref_x[2] ^ ref_x[3], 1'b0,
            next_seq_pc());
    // shift amount 35 leaves 3 in the low five bits.
    add_row(i_type(12'h023, 5'd0, 3'b000, 5'd10), 1'b1, 5'd10, 32'd35, 1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd10, 5'd3, 3'b001, 5'd11), 1'b1, 5'd11,
            ref_x[3] << ref_x[10][4:0], 1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd10, 5'd2, 3'b101, 5'd12), 1'b1, 5'd12,
            ref_x[2] >> ref_x[10][4:0], 1'b0, next_seq_pc());
    add_row(r_type(7'h20, 5'd10, 5'd2, 3'b101, 5'd13), 1'b1, 5'd13,
            ref_x[2][31] ? ~(~ref_x[2] >> ref_x[10][4:0]) : ref_x[2] >> ref_x[10][4:0],
            1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd14), 1'b1, 5'd14,
            32'($signed(ref_x[2]) < $signed(ref_x[3])), 1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd15), 1'b1, 5'd15,
            32'(ref_x[2] < ref_x[3]), 1'b0, next_seq_pc());
    taken = (ref_x[1] == ref_x[1]);
    add_row(branch_instr(13'd8, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, 32'd0, 1'b0,
            taken ? this_pc() + 32'd8 : next_seq_pc());
    skip_row(i_type(12'd1, 5'd0, 3'b000, 5'd20));
    taken = ($signed(ref_x[2]) < $signed(ref_x[3]));
    add_row(branch_instr(13'd8, 5'd3, 5'd2, 3'b100), 1'b0, 5'd0, 32'd0, 1'b0,
            taken ? this_pc() + 32'd8 : next_seq_pc());
    skip_row(i_type(12'd2, 5'd0, 3'b000, 5'd20));
    taken = (ref_x[1] != ref_x[1]);
    add_row(branch_instr(13'd8, 5'd1, 5'd1, 3'b001), 1'b0, 5'd0, 32'd0, 1'b0,
            taken ? this_pc() + 32'd8 : next_seq_pc());
    taken = !($signed(ref_x[2]) < $signed(ref_x[3]));
    add_row(branch_instr(13'd8, 5'd3, 5'd2, 3'b101), 1'b0, 5'd0, 32'd0, 1'b0,
            taken ? this_pc() + 32'd8 : next_seq_pc());
    add_row(jal_instr(21'd12, 5'd16), 1'b1, 5'd16, this_pc() + 32'd4, 1'b0,
            this_pc() + 32'd12);
    skip_row(i_type(12'd3, 5'd0, 3'b000, 5'd20));
    skip_row(i_type(12'd4, 5'd0, 3'b000, 5'd20));
    add_row(i_type(12'h155, 5'd0, 3'b000, 5'd0), 1'b1, 5'd0, 32'h155, 1'b0, next_seq_pc());
    add_row(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd17), 1'b1, 5'd17, ref_x[0] + ref_x[0], 1'b0,
            next_seq_pc());
    add_row(32'h0, 1'b0, 5'd0, 32'd0, 1'b1, next_seq_pc());
    add_row(i_type(12'd7, 5'd0, 3'b000, 5'd18), 1'b1, 5'd18, 32'd7, 1'b0, next_seq_pc());
    add_row(i_type(12'd1, 5'd18, 3'b000, 5'd19), 1'b1, 5'd19, ref_x[18] + 32'd1, 1'b0,
            next_seq_pc());
    add_row(r_type(7'h00, 5'd19, 5'd0, 3'b011, 5'd21), 1'b1, 5'd21,
            32'(ref_x[0] < ref_x[19]), 1'b0, next_seq_pc());
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // load and step
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk_i);
      imem_we_i    = 1'b1;
      imem_addr_i  = i[5:0];
      imem_wdata_i = prog_word[i];
    end
    @(negedge clk_i);
    imem_we_i = 1'b0;
  endtask

  task automatic run_program();
    logic [31:0] exp_pc;
    int          idx;
    int          pause_left;
    bit          paused;
    bit          finished;
    exp_pc     = 32'd0;
    pause_left = 0;
    paused     = 1'b0;
    finished   = 1'b0;
    while (!finished) begin
      @(negedge clk_i);
      en_i = (pause_left == 0);
      #(half_period / 2);  // outputs have settled, the next rising edge is far.
      idx = int'(exp_pc[7:2]);
      compare_value("pc_o", pc_o, exp_pc);
      if (pause_left > 0) begin
        compare_value("retire_we_o", 32'(retire_we_o), 32'd0);
        pause_left = pause_left - 1;
      end else begin
        compare_value("retire_we_o", 32'(retire_we_o), 32'(exp_we[idx]));
        compare_value("illegal_o", 32'(illegal_o), 32'(exp_ill[idx]));
        if (exp_we[idx]) begin
          compare_value("retire_rd_o", 32'(retire_rd_o), 32'(exp_rd[idx]));
          compare_value("retire_data_o", retire_data_o, exp_data[idx]);
        end
        exp_pc = exp_next[idx];
        if (idx == pause_row && !paused) begin
          pause_left = 3;
          paused     = 1'b1;
        end
        finished = (idx == prog_len - 1);
      end
    end
    @(negedge clk_i);
    en_i = 1'b0;
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    en_i         = 1'b0;
    imem_we_i    = 1'b0;
    imem_addr_i  = 6'd0;
    imem_wdata_i = 32'd0;
    n_rows       = 0;
    error_count  = 0;
    cycle_count  = 0;
    seed         = 32'h89d1;
    for (int i = 0; i < 32; i++) begin
      ref_x[i] = 32'd0;
    end
    build_program();
    if (n_rows != prog_len) begin
      error_count = error_count + 1;
      $display("program table holds %0d rows instead of %0d", n_rows, prog_len);
    end
    repeat (reset_cycles) @(negedge clk_i);
    rst_i = 1'b0;
    #(half_period / 2);
    // memory is cleared, so word 0 decodes as illegal.
    compare_value("pc_o", pc_o, 32'd0);
    compare_value("retire_we_o", 32'(retire_we_o), 32'd0);
    compare_value("illegal_o", 32'(illegal_o), 32'd1);
    load_program();
    run_program();
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
core_isa_pkg.sv
core_alu_pkg.sv
instr_mem.sv
reg_file.sv
instr_decode.sv
alu_execute.sv
wb_result.sv
core_top.sv
core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit code of the simulation.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
